// ==== dv/div_cases.txt ====
# op dividend divisor expected, all hex
# op 0 div, 1 divu, 2 rem, 3 remu, 4 divw, 5 divuw, 6 remw, 7 remuw
1 0000000000000064 0000000000000007 000000000000000e
3 0000000000000064 0000000000000007 0000000000000002
1 0000000000000005 0000000000000009 0000000000000000
3 0000000000000005 0000000000000009 0000000000000005
1 ffffffffffffffff ffffffffffffffff 0000000000000001
3 ffffffffffffffff ffffffffffffffff 0000000000000000
0 0000000000000007 0000000000000002 0000000000000003
2 0000000000000007 0000000000000002 0000000000000001
0 fffffffffffffff9 0000000000000002 fffffffffffffffd
2 fffffffffffffff9 0000000000000002 ffffffffffffffff
0 0000000000000007 fffffffffffffffe fffffffffffffffd
2 0000000000000007 fffffffffffffffe 0000000000000001
0 fffffffffffffff9 fffffffffffffffe 0000000000000003
2 fffffffffffffff9 fffffffffffffffe ffffffffffffffff
0 8000000000000000 0000000000000002 c000000000000000
0 0000000000001234 0000000000000000 ffffffffffffffff
2 0000000000001234 0000000000000000 0000000000001234
3 fffffffffffffffe 0000000000000000 fffffffffffffffe
0 8000000000000000 ffffffffffffffff 8000000000000000
2 8000000000000000 ffffffffffffffff 0000000000000000
4 fffffffffffffff9 1234567800000002 fffffffffffffffd
6 fffffffffffffff9 1234567800000002 ffffffffffffffff
5 00000000ffffffff 0000000000000002 000000007fffffff
7 0000000080000005 ffffffff00000010 0000000000000005
4 0000000000000005 ffffffff00000000 ffffffffffffffff
6 0000000180000000 0000000000000000 ffffffff80000000
7 000000007ffffff0 0000000000000000 000000007ffffff0
4 0000000080000000 00000000ffffffff ffffffff80000000
6 0000000080000000 00000000ffffffff 0000000000000000

// ==== div_unit.f ====
design/div_pkg.sv
design/div_operand_prep.sv
design/div_iter_core.sv
design/div_result_fixup.sv
design/div_unit.sv
dv/div_unit_tb.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - files:
      - design/div_pkg.sv
      - design/div_operand_prep.sv
      - design/div_iter_core.sv
      - design/div_result_fixup.sv
      - design/div_unit.sv
  - target: test
    files:
      - dv/div_unit_tb.sv

// ==== dv/div_unit_tb.sv ====
`default_nettype none

module div_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned n_random        = 200;
  localparam int unsigned max_file_cases  = 64;
  localparam int unsigned reset_cycles    = 16;
  localparam int unsigned watchdog_cycles = (max_file_cases + n_random) * 80 + reset_cycles;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic              req_ready;
  div_pkg::div_req_t req;
  logic              rsp_valid;
  logic              rsp_ready;
  div_pkg::div_rsp_t rsp;
  logic [31:0]       rng = 32'h4df1;

  div_unit UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_i       (req),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_o       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ========================================
  // failure reporting
  // ========================================
  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp, act);
    $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("%0t ns %s", $time, what);
    abort_run();
  endtask

  // ========================================
  // random source and reference model
  // ========================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  // architectural result, zero divisor and overflow handled before dividing
  function automatic logic [63:0] ref_result(input div_pkg::div_op_e op,
                                             input logic [63:0] a, b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [31:0]        w;
    logic               ovf64;
    logic               ovf32;
    sa    = a;
    sb    = b;
    wa    = a[31:0];
    wb    = b[31:0];
    ovf64 = (a == 64'h8000000000000000) && (b == '1);
    ovf32 = (a[31:0] == 32'h80000000) && (b[31:0] == 32'hffffffff);
    case (op)
      div_pkg::op_divu: return (b == '0) ? '1 : a / b;
      div_pkg::op_remu: return (b == '0) ? a : a % b;
      div_pkg::op_div: begin
        if (b == '0) return '1;
        if (ovf64) return a;
        return sa / sb;
      end
      div_pkg::op_rem: begin
        if (b == '0) return a;
        if (ovf64) return '0;
        return sa % sb;
      end
      div_pkg::op_divuw: begin
        if (b[31:0] == '0) return '1;
        w = a[31:0] / b[31:0];
        return sext32(w);
      end
      div_pkg::op_remuw: begin
        if (b[31:0] == '0) return sext32(a[31:0]);
        w = a[31:0] % b[31:0];
        return sext32(w);
      end
      div_pkg::op_divw: begin
        if (b[31:0] == '0) return '1;
        if (ovf32) return sext32(a[31:0]);
        w = wa / wb;
        return sext32(w);
      end
      default: begin  // remw
        if (b[31:0] == '0) return sext32(a[31:0]);
        if (ovf32) return '0;
        w = wa % wb;
        return sext32(w);
      end
    endcase
  endfunction

  // cycles from the accepting edge to rsp_valid_o, that edge counted
  function automatic int unsigned expected_latency(input div_pkg::div_op_e op,
                                                   input logic [63:0] a, b);
    logic word_op;
    logic signed_op;
    logic zero;
    logic ovf;
    word_op   = op inside {div_pkg::op_divw, div_pkg::op_divuw, div_pkg::op_remw,
                           div_pkg::op_remuw};
    signed_op = op inside {div_pkg::op_div, div_pkg::op_rem, div_pkg::op_divw,
                           div_pkg::op_remw};
    zero = word_op ? (b[31:0] == '0) : (b == '0);
    ovf  = signed_op && (word_op ? (a[31:0] == 32'h80000000 && b[31:0] == '1) :
                                   (a == 64'h8000000000000000 && b == '1));
    if (zero || ovf) return 1;
    return word_op ? 33 : 65;
  endfunction

  // ========================================
  // one request through to its response
  // ========================================
  task automatic run_case(input div_pkg::div_op_e op, input logic [63:0] a, b, exp,
                          input int unsigned stall);
    int unsigned cycles;
    int unsigned lat;
    logic [63:0] held;
    lat          = expected_latency(op, a, b);
    req_valid    = 1'b1;
    req.op       = op;
    req.dividend = a;
    req.divisor  = b;
    while (!req_ready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);  // accepting edge
    #2;
    req_valid = 1'b0;
    cycles    = 1;
    while (!rsp_valid) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    assert (cycles == lat) else report_mismatch("rsp_valid_o latency", lat, cycles);
    assert (rsp.result == exp) else report_mismatch("rsp_o.result", exp, rsp.result);
    held = rsp.result;
    repeat (stall) begin
      @(posedge clk);
      #2;
      assert (rsp_valid && !req_ready)
        else report_problem("handshake state changed while rsp_ready_i was low");
      assert (rsp.result == held) else report_mismatch("rsp_o.result", held, rsp.result);
    end
    rsp_ready = 1'b1;
    @(posedge clk);
    #2;
    rsp_ready = 1'b0;
    assert (!rsp_valid && req_ready)
      else report_problem("unit did not return to idle after the response was taken");
  endtask

  // ========================================
  // stimulus
  // ========================================
  initial begin
    int          fd;
    int          n;
    int unsigned n_file;
    logic [7:0]  op_raw;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] exp;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [8*120-1:0] skip_line;
    div_pkg::div_op_e op;
    n_file    = 0;
    rst_n     = 1'b1;  // reset is active high
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b0;
    assert (req_ready && !rsp_valid) else report_problem("wrong handshake state after reset");

    fd = $fopen("dv/div_cases.txt", "r");
    if (fd == 0) report_problem("cannot open dv/div_cases.txt for reading");
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %h %h %h\n", op_raw, a, b, exp);
      if (n == 4) begin
        draw(r4);
        run_case(div_pkg::div_op_e'(op_raw[2:0]), a, b, exp, r4[2:0]);
        n_file++;
      end else begin
        n = $fgets(skip_line, fd);  // comment line
      end
    end
    $fclose(fd);
    assert (n_file > 0) else report_problem("no cases were read from dv/div_cases.txt");

    for (int i = 0; i < n_random; i++) begin
      draw(r0);
      draw(r1);
      draw(r2);
      draw(r3);
      draw(r4);
      a = {r0, r1};
      b = {r2, r3};
      case (r4[1:0])
        2'd0: b = b >> r4[7:2];  // short divisor, long quotient
        2'd1: a = a >> r4[7:2];
        2'd2: b = r4[8] ? '0 : '1;
        default: ;
      endcase
      op = div_pkg::div_op_e'(r4[14:12]);
      run_case(op, a, b, ref_result(op, a, b), r4[18:16]);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    report_problem("timeout, the divider stopped responding before all cases finished");
  end

endmodule

`default_nettype wire

// ==== design/div_unit.sv ====
`default_nettype none

module div_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  div_pkg::div_req_t req_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output div_pkg::div_rsp_t rsp_o
);

  div_pkg::div_prep_t       prep;
  div_pkg::div_ctl_t        ctl;
  logic [div_pkg::xlen-1:0] quot_mag;
  logic [div_pkg::xlen-1:0] rem_mag;

  // ========================================
  // prep, iterate, fixup
  // ========================================
  div_operand_prep u_prep (
    .req_i  (req_i),
    .prep_o (prep)
  );

  div_iter_core u_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .prep_i      (prep),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .ctl_o       (ctl),
    .quot_mag_o  (quot_mag),
    .rem_mag_o   (rem_mag)
  );

  div_result_fixup u_fixup (
    .ctl_i      (ctl),
    .quot_mag_i (quot_mag),
    .rem_mag_i  (rem_mag),
    .rsp_o      (rsp_o)
  );

endmodule

`default_nettype wire

// ==== design/div_result_fixup.sv ====
`default_nettype none

module div_result_fixup (
  input  div_pkg::div_ctl_t        ctl_i,
  input  logic [div_pkg::xlen-1:0] quot_mag_i,
  input  logic [div_pkg::xlen-1:0] rem_mag_i,
  output div_pkg::div_rsp_t        rsp_o
);

  logic [div_pkg::xlen-1:0] mag;
  logic                     neg;
  logic [div_pkg::xlen-1:0] signed_val;
  logic [div_pkg::xlen-1:0] word_val;

  // pick the half the op asked for
  assign mag = ctl_i.want_rem ? rem_mag_i : quot_mag_i;
  assign neg = ctl_i.want_rem ? ctl_i.r_neg : ctl_i.q_neg;

  assign signed_val = neg ? (~mag + 1'b1) : mag;

  // word results always sign-extend, even for unsigned ops
  assign word_val = {{(div_pkg::xlen-div_pkg::word_w){signed_val[div_pkg::word_w-1]}},
                     signed_val[div_pkg::word_w-1:0]};

  always_comb begin
    if (ctl_i.exc) begin
      rsp_o.result = ctl_i.exc_value;  // already in final form
    end else if (ctl_i.is_word) begin
      rsp_o.result = word_val;
    end else begin
      rsp_o.result = signed_val;
    end
  end

endmodule

`default_nettype wire

// ==== design/div_iter_core.sv ====
`default_nettype none

module div_iter_core (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  div_pkg::div_prep_t       prep_i,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output div_pkg::div_ctl_t        ctl_o,
  output logic [div_pkg::xlen-1:0] quot_mag_o,
  output logic [div_pkg::xlen-1:0] rem_mag_o
);

  typedef enum logic [1:0] {
    st_idle   = 2'b00,
    st_iter   = 2'b01,
    st_finish = 2'b10
  } state_e;

  state_e                     state_q;
  state_e                     state_d;
  div_pkg::cnt_t              cnt_q;
  logic [2*div_pkg::xlen-1:0] rq_q;     // {remainder, quotient}
  logic [div_pkg::xlen-1:0]   dvsr_q;
  div_pkg::div_ctl_t          ctl_q;
  logic [div_pkg::xlen:0]     trial;    // 65 bits, shifted remainder minus divisor
  logic                       accept;
  logic                       last_iter;

  assign accept    = req_valid_i & (state_q == st_idle);
  assign last_iter = (cnt_q == div_pkg::cnt_t'(1));

  // top 65 bits after the shift, so the bit leaving rq_q is kept
  assign trial = rq_q[2*div_pkg::xlen-1:div_pkg::xlen-1] - {1'b0, dvsr_q};

  // ========================================
  // control FSM
  // ========================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_valid_i) begin
          state_d = prep_i.ctl.exc ? st_finish : st_iter;  // exceptions skip iteration
        end
      end
      st_iter: begin
        if (last_iter) begin
          state_d = st_finish;
        end
      end
      st_finish: begin
        if (rsp_ready_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        cnt_q <= prep_i.iters;
      end else if (state_q == st_iter) begin
        cnt_q <= cnt_q - div_pkg::cnt_t'(1);
      end
    end
  end

  // ========================================
  // shift-subtract datapath
  // ========================================
  always_ff @(posedge clk) begin
    if (accept) begin
      rq_q   <= {{div_pkg::xlen{1'b0}}, prep_i.mag_dividend};
      dvsr_q <= prep_i.mag_divisor;
      ctl_q  <= prep_i.ctl;
    end else if (state_q == st_iter) begin
      if (!trial[div_pkg::xlen]) begin
        // fits, keep difference and set quotient bit
        rq_q <= {trial[div_pkg::xlen-1:0], rq_q[div_pkg::xlen-2:0], 1'b1};
      end else begin
        rq_q <= {rq_q[2*div_pkg::xlen-2:0], 1'b0};  // restore
      end
    end
  end

  assign req_ready_o = (state_q == st_idle);
  assign rsp_valid_o = (state_q == st_finish);
  assign ctl_o       = ctl_q;
  assign quot_mag_o  = rq_q[div_pkg::xlen-1:0];
  assign rem_mag_o   = rq_q[2*div_pkg::xlen-1:div_pkg::xlen];

endmodule

`default_nettype wire

// ==== design/div_operand_prep.sv ====
`default_nettype none

module div_operand_prep (
  input  div_pkg::div_req_t  req_i,
  output div_pkg::div_prep_t prep_o
);

  logic                     is_word;
  logic                     want_rem;
  logic                     is_uns;
  logic [div_pkg::xlen-1:0] a_sext;   // word dividend, always sign-extended
  logic [div_pkg::xlen-1:0] a_word;   // word dividend, signed or unsigned
  logic [div_pkg::xlen-1:0] b_word;
  logic [div_pkg::xlen-1:0] a_ext;
  logic [div_pkg::xlen-1:0] b_ext;
  logic                     a_neg;
  logic                     b_neg;
  logic [div_pkg::xlen-1:0] a_mag;
  logic [div_pkg::xlen-1:0] b_mag;
  logic [div_pkg::xlen-1:0] min_val;
  logic                     div_zero;
  logic                     div_ovf;

  assign is_word  = req_i.op[2];
  assign want_rem = req_i.op[1];
  assign is_uns   = req_i.op[0];

  // ========================================
  // operand forming
  // ========================================
  assign a_sext = {{(div_pkg::xlen-div_pkg::word_w){req_i.dividend[div_pkg::word_w-1]}},
                   req_i.dividend[div_pkg::word_w-1:0]};
  assign a_word = {{(div_pkg::xlen-div_pkg::word_w){req_i.dividend[div_pkg::word_w-1] & ~is_uns}},
                   req_i.dividend[div_pkg::word_w-1:0]};
  assign b_word = {{(div_pkg::xlen-div_pkg::word_w){req_i.divisor[div_pkg::word_w-1] & ~is_uns}},
                   req_i.divisor[div_pkg::word_w-1:0]};

  assign a_ext = is_word ? a_word : req_i.dividend;
  assign b_ext = is_word ? b_word : req_i.divisor;

  assign a_neg = ~is_uns & a_ext[div_pkg::xlen-1];
  assign b_neg = ~is_uns & b_ext[div_pkg::xlen-1];

  assign a_mag = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign b_mag = b_neg ? (~b_ext + 1'b1) : b_ext;

  // ========================================
  // exception detection
  // ========================================
  // most negative value at the op width
  assign min_val = is_word ?
                   {{(div_pkg::xlen-div_pkg::word_w+1){1'b1}}, {(div_pkg::word_w-1){1'b0}}} :
                   {1'b1, {(div_pkg::xlen-1){1'b0}}};

  assign div_zero = (b_ext == '0);
  assign div_ovf  = ~is_uns & (a_ext == min_val) & (&b_ext);

  always_comb begin
    prep_o.ctl.want_rem = want_rem;
    prep_o.ctl.is_word  = is_word;
    prep_o.ctl.q_neg    = a_neg ^ b_neg;
    prep_o.ctl.r_neg    = a_neg;  // remainder follows the dividend
    prep_o.ctl.exc      = div_zero | div_ovf;

    if (div_zero) begin
      prep_o.ctl.exc_value = want_rem ? (is_word ? a_sext : req_i.dividend) : '1;
    end else if (div_ovf) begin
      prep_o.ctl.exc_value = want_rem ? '0 : a_ext;
    end else begin
      prep_o.ctl.exc_value = '0;
    end

    // word dividend goes high so 32 shifts use it up
    prep_o.mag_dividend = is_word ? {a_mag[div_pkg::word_w-1:0], {div_pkg::word_w{1'b0}}} : a_mag;
    prep_o.mag_divisor  = b_mag;

    if (prep_o.ctl.exc) begin
      prep_o.iters = '0;
    end else begin
      prep_o.iters = is_word ? div_pkg::cnt_t'(div_pkg::word_w) : div_pkg::cnt_t'(div_pkg::xlen);
    end
  end

endmodule

`default_nettype wire

// ==== design/div_pkg.sv ====
`default_nettype none

package div_pkg;

  // ========================================
  // widths
  // ========================================
  localparam int unsigned xlen   = 64;
  localparam int unsigned word_w = 32;
  localparam int unsigned cnt_w  = 7;  // must hold xlen

  typedef logic [cnt_w-1:0] cnt_t;

  // ========================================
  // operation codes
  // ========================================
  // bit 2 word, bit 1 remainder, bit 0 unsigned
  typedef enum logic [2:0] {
    op_div   = 3'b000,
    op_divu  = 3'b001,
    op_rem   = 3'b010,
    op_remu  = 3'b011,
    op_divw  = 3'b100,
    op_divuw = 3'b101,
    op_remw  = 3'b110,
    op_remuw = 3'b111
  } div_op_e;

  // ========================================
  // transfer structs
  // ========================================
  typedef struct packed {
    div_op_e         op;
    logic [xlen-1:0] dividend;  // rs1
    logic [xlen-1:0] divisor;   // rs2
  } div_req_t;

  typedef struct packed {
    logic [xlen-1:0] result;
  } div_rsp_t;

  // travels with the op to steer the fixup
  typedef struct packed {
    logic            want_rem;
    logic            is_word;
    logic            q_neg;
    logic            r_neg;
    logic            exc;        // zero divisor or signed overflow
    logic [xlen-1:0] exc_value;  // final result when exc
  } div_ctl_t;

  typedef struct packed {
    logic [xlen-1:0] mag_dividend;  // word ops sit in the upper half
    logic [xlen-1:0] mag_divisor;
    cnt_t            iters;
    div_ctl_t        ctl;
  } div_prep_t;

endpackage

`default_nettype wire
